//--- project.f
+incdir+source
source/pe_pkg.sv
source/cordic_segment.sv
source/cordic_unit.sv
source/lane_router.sv
source/angle_store.sv
source/givens_pe.sv
tb/givens_pe_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds and runs the Givens PE testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 -f project.f --top-module givens_pe_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vgivens_pe_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" sim.log; then
    exit 0
fi
echo "simulation reported failure"
exit 1

//--- tb/givens_pe_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_consts.svh"

module givens_pe_tb
    import pe_pkg::*;
();

    localparam int MAX_CYCLES = 400;    // about 250 cycles of stimulus and drain

    typedef struct packed {
        int unsigned stamp;    // cycle count when the issue was modeled
        coord_pair_t p0;
        coord_pair_t p1;
    } expect_t;

    logic        clk;
    logic        rst_n;
    logic [1:0]  valid_i;
    pe_scheme_e  scheme_i;
    coord_pair_t pair0_i;
    coord_pair_t pair1_i;
    coord_pair_t pair0_o;
    coord_pair_t pair1_o;

    logic [31:0] seed = 32'h136e_8d40;
    int unsigned cycle_cnt;
    int          n_checks;
    int          n_errors;
    logic        running;
    dir_t        ang [0:1];    // last vectoring angle per lane
    expect_t     exp_q [$];
    expect_t     cur;

    givens_pe uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .valid_i  (valid_i),
        .scheme_i (scheme_i),
        .pair0_i  (pair0_i),
        .pair1_i  (pair1_i),
        .pair0_o  (pair0_o),
        .pair1_o  (pair1_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic coord_t rand_coord();
        logic [31:0] r;
        r = next_rand();
        return coord_t'($signed(r[31:16]));    // within +-2^15
    endfunction

    // inverse gain in Q14, keeps the sign and bits 30..14, rounds on bit 13
    function automatic coord_t gain_fix(input ext_coord_t v);
        longint      p;
        logic [63:0] pb;
        p = longint'(v) * longint'(`PE_GAIN);
        pb = p;
        return {p < 0, pb[30:14]} + {17'd0, pb[13]};
    endfunction

    function automatic coord_pair_t cordic_ref(input cordic_mode_e m_first,
                                               input cordic_mode_e m_rest,
                                               input coord_pair_t src,
                                               input dir_t rot,
                                               output dir_t used);
        ext_coord_t  x;
        ext_coord_t  y;
        ext_coord_t  xs;
        ext_coord_t  ys;
        logic        vec;
        coord_pair_t res;
        x = ext_coord_t'(src.x);
        y = ext_coord_t'(src.y);
        for (int i = 0; i < `PE_ITER_NUM; i++) begin
            vec = (i < `PE_SEG1_FIRST) ? (m_first == VECTOR) : (m_rest == VECTOR);
            used[i] = vec ? (x[`PE_WIDTH] ^ y[`PE_WIDTH]) : rot[i];
            xs = x >>> i;
            ys = y >>> i;
            if (used[i]) begin
                x = x - ys;
                y = y + xs;
            end else begin
                x = x + ys;
                y = y - xs;
            end
        end
        res.x = gain_fix(x);
        res.y = gain_fix(y);
        return res;
    endfunction

    // an idle unit vectors only in its first segment, then rotates by the stored angle
    function automatic expect_t model_issue(input logic [1:0] v, input pe_scheme_e s,
                                            input coord_pair_t a, input coord_pair_t b);
        logic         swap;
        logic         follow;
        cordic_mode_e m0;
        cordic_mode_e m1;
        coord_pair_t  u0;
        coord_pair_t  u1;
        coord_pair_t  r0;
        coord_pair_t  r1;
        dir_t         d0;
        dir_t         d1;
        expect_t      e;
        swap   = (s == SCHEME_SWAP_VR) || (s == SCHEME_SWAP_RR);
        follow = (s == SCHEME_SWAP_VR) && (v == 2'b11);    // lane 1 takes unit 0's fresh angle
        m0 = (s == SCHEME_VV || s == SCHEME_SWAP_VR) ? VECTOR : ROTATE;
        m1 = (s == SCHEME_VV) ? VECTOR : ROTATE;
        u0 = a;
        u1 = b;
        if (swap) begin
            u0.y = b.x;
            u1.x = a.y;
        end
        r0 = cordic_ref(m0, v[0] ? m0 : ROTATE, u0, ang[0], d0);
        r1 = cordic_ref(m1, v[1] ? m1 : ROTATE, u1, follow ? d0 : ang[1], d1);
        if (v[0] && m0 == VECTOR)
            ang[0] = d0;
        if (v[1] && s == SCHEME_VV)
            ang[1] = d1;
        if (follow)
            ang[1] = d0;
        e.stamp = cycle_cnt;
        e.p0 = r0;
        e.p1 = r1;
        if (swap) begin
            e.p0.y = r1.x;
            e.p1.x = r0.y;
        end
        return e;
    endfunction

    task automatic report_pair(input string what, input coord_pair_t got, input coord_pair_t want);
        n_errors++;
        $display("Error at %0d ns: %s got (%0d, %0d), expected (%0d, %0d)",
                 $time, what, got.x, got.y, want.x, want.y);
    endtask

    task automatic issue(input logic [1:0] v, input pe_scheme_e s);
        @(posedge clk);
        valid_i   <= v;
        scheme_i  <= s;
        pair0_i.x <= rand_coord();
        pair0_i.y <= rand_coord();
        pair1_i.x <= rand_coord();
        pair1_i.y <= rand_coord();
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            valid_i <= 2'b00;
        end
    endtask

    // inputs are stable at the falling edge and are sampled at the next rising one
    always @(negedge clk) begin
        if (running)
            exp_q.push_back(model_issue(valid_i, scheme_i, pair0_i, pair1_i));
    end

    always @(negedge clk) begin
        if (exp_q.size() > 0 && exp_q[0].stamp + `PE_PIPE_NUM == cycle_cnt) begin
            cur = exp_q.pop_front();
            n_checks++;
            if (pair0_o !== cur.p0)
                report_pair("lane 0", pair0_o, cur.p0);
            if (pair1_o !== cur.p1)
                report_pair("lane 1", pair1_o, cur.p1);
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        logic [31:0] r;
        rst_n     = 1'b0;
        valid_i   = 2'b00;
        scheme_i  = SCHEME_VV;
        pair0_i.x = rand_coord();    // live data while reset holds the pipeline
        pair0_i.y = rand_coord();
        pair1_i.x = rand_coord();
        pair1_i.y = rand_coord();
        n_checks  = 0;
        n_errors  = 0;
        running   = 1'b0;
        ang[0]    = '0;
        ang[1]    = '0;
        repeat (5) @(posedge clk);
        rst_n   <= 1'b1;
        running  = 1'b1;
        idle(3);
        @(negedge clk);
        n_checks++;
        if (pair0_o !== '0)
            report_pair("lane 0 after reset", pair0_o, '0);
        if (pair1_o !== '0)
            report_pair("lane 1 after reset", pair1_o, '0);
        repeat (20) issue(2'b11, SCHEME_VV);
        repeat (6) begin
            issue(2'b11, SCHEME_VV);
            idle(5);
            issue(2'b11, SCHEME_RR);
            issue(2'b11, SCHEME_VV);
            issue(2'b11, SCHEME_RR);    // right behind the vectoring, uses the bypass
            idle(2);
        end
        repeat (6) begin
            issue(2'b11, SCHEME_SWAP_VR);
            idle(3);
            issue(2'b11, SCHEME_RR);
            issue(2'b01, SCHEME_SWAP_VR);
            issue(2'b11, SCHEME_RR);
        end
        repeat (8) issue(2'b11, SCHEME_SWAP_RR);
        repeat (100) begin
            r = next_rand();
            issue(r[1:0], pe_scheme_e'(r[3:2]));
        end
        @(posedge clk);
        valid_i <= 2'b00;
        running  = 1'b0;
        while (exp_q.size() != 0)
            @(posedge clk);
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/givens_pe.sv
`timescale 1ns/1ps
`default_nettype none

module givens_pe
    import pe_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,
    input  wire logic [1:0]  valid_i,
    input  wire pe_scheme_e  scheme_i,
    input  wire coord_pair_t pair0_i,
    input  wire coord_pair_t pair1_i,
    output coord_pair_t      pair0_o,
    output coord_pair_t      pair1_o
);

    logic [1:0]   start;
    cordic_mode_e mode0;
    cordic_mode_e mode1;
    coord_pair_t  upair0;
    coord_pair_t  upair1;
    coord_pair_t  res0;
    coord_pair_t  res1;
    dir_t         dir0;
    dir_t         dir1;
    seg_val_t     val0;
    seg_val_t     val1;
    dir_t         ang_dir1;    // lane 1 direction stream after the swap merge
    seg_val_t     ang_val1;
    dir_t         rot0;
    dir_t         rot1;

    lane_router u_router (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid_i    (valid_i),
        .scheme_i   (scheme_i),
        .pair0_i    (pair0_i),
        .pair1_i    (pair1_i),
        .res0_i     (res0),
        .res1_i     (res1),
        .dir0_i     (dir0),
        .dir1_i     (dir1),
        .val0_i     (val0),
        .val1_i     (val1),
        .start_o    (start),
        .mode0_o    (mode0),
        .mode1_o    (mode1),
        .upair0_o   (upair0),
        .upair1_o   (upair1),
        .pair0_o    (pair0_o),
        .pair1_o    (pair1_o),
        .ang_dir1_o (ang_dir1),
        .ang_val1_o (ang_val1)
    );

    cordic_unit u_cordic0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (start[0]),
        .mode_i    (mode0),
        .pair_i    (upair0),
        .dir_i     (rot0),
        .pair_o    (res0),
        .dir_o     (dir0),
        .seg_val_o (val0)
    );

    cordic_unit u_cordic1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (start[1]),
        .mode_i    (mode1),
        .pair_i    (upair1),
        .dir_i     (rot1),
        .pair_o    (res1),
        .dir_o     (dir1),
        .seg_val_o (val1)
    );

    angle_store u_angles (
        .clk    (clk),
        .rst_n  (rst_n),
        .dir0_i (dir0),
        .val0_i (val0),
        .dir1_i (ang_dir1),
        .val1_i (ang_val1),
        .rot0_o (rot0),
        .rot1_o (rot1)
    );

endmodule

`default_nettype wire

//--- source/angle_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_consts.svh"

module angle_store
    import pe_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n,
    input  wire dir_t      dir0_i,
    input  wire seg_val_t  val0_i,
    input  wire dir_t      dir1_i,
    input  wire seg_val_t  val1_i,
    output dir_t           rot0_o,
    output dir_t           rot1_o
);

    dir_t      ang0_q;
    dir_t      ang1_q;
    wire dir_t we0;    // per-bit write enable from the segment valids
    wire dir_t we1;

    for (genvar i = 0; i < `PE_ITER_NUM; i++) begin : g_we
        localparam int SEG = (i >= `PE_SEG2_FIRST) ? 2 : ((i >= `PE_SEG1_FIRST) ? 1 : 0);
        assign we0[i] = val0_i[SEG];
        assign we1[i] = val1_i[SEG];
    end

    // fresh bits bypass the register in the cycle they appear
    assign rot0_o = (ang0_q & ~we0) | (dir0_i & we0);
    assign rot1_o = (ang1_q & ~we1) | (dir1_i & we1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ang0_q <= '0;
            ang1_q <= '0;
        end else begin
            ang0_q <= rot0_o;
            ang1_q <= rot1_o;
        end
    end

endmodule

`default_nettype wire

//--- source/lane_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_consts.svh"

module lane_router
    import pe_pkg::*;
(
    input  wire               clk,
    input  wire               rst_n,
    input  wire logic [1:0]   valid_i,
    input  wire pe_scheme_e   scheme_i,
    input  wire coord_pair_t  pair0_i,
    input  wire coord_pair_t  pair1_i,
    input  wire coord_pair_t  res0_i,
    input  wire coord_pair_t  res1_i,
    input  wire dir_t         dir0_i,
    input  wire dir_t         dir1_i,
    input  wire seg_val_t     val0_i,
    input  wire seg_val_t     val1_i,
    output logic [1:0]        start_o,
    output cordic_mode_e      mode0_o,
    output cordic_mode_e      mode1_o,
    output coord_pair_t       upair0_o,
    output coord_pair_t       upair1_o,
    output coord_pair_t       pair0_o,
    output coord_pair_t       pair1_o,
    output dir_t              ang_dir1_o,
    output seg_val_t          ang_val1_o
);

    logic                    swap;
    logic [`PE_PIPE_NUM-1:0] swap_q;
    logic [1:0]              take_q;    // lane 1 adopts unit 0's angle, segments 1 and 2
    seg_val_t                swap_seg;
    seg_val_t                take_seg;
    wire dir_t               sel_dir;

    always_comb begin
        case (scheme_i)
            SCHEME_RR: begin
                swap    = 1'b0;
                mode0_o = ROTATE;
                mode1_o = ROTATE;
            end
            SCHEME_SWAP_VR: begin
                swap    = 1'b1;
                mode0_o = VECTOR;
                mode1_o = ROTATE;
            end
            SCHEME_SWAP_RR: begin
                swap    = 1'b1;
                mode0_o = ROTATE;
                mode1_o = ROTATE;
            end
            default: begin
                swap    = 1'b0;
                mode0_o = VECTOR;
                mode1_o = VECTOR;
            end
        endcase
    end

    assign start_o = valid_i;

    // under swap unit 0 sees the x coordinates and unit 1 the y coordinates
    always_comb begin
        upair0_o = pair0_i;
        upair1_o = pair1_i;
        if (swap) begin
            upair0_o.y = pair1_i.x;
            upair1_o.x = pair0_i.y;
        end
    end

    always_comb begin
        pair0_o = res0_i;
        pair1_o = res1_i;
        if (swap_q[`PE_PIPE_NUM-1]) begin
            pair0_o.y = res1_i.x;
            pair1_o.x = res0_i.y;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            swap_q <= '0;
            take_q <= '0;
        end else begin
            swap_q <= {swap_q[`PE_PIPE_NUM-2:0], swap};
            take_q <= {take_q[0], swap & valid_i[1]};    // idle lane 1 keeps its angle
        end
    end

    assign swap_seg = {swap_q[1], swap_q[0], swap};
    assign take_seg = {take_q, swap & valid_i[1]};

    for (genvar i = 0; i < `PE_ITER_NUM; i++) begin : g_sel
        localparam int SEG = (i >= `PE_SEG2_FIRST) ? 2 : ((i >= `PE_SEG1_FIRST) ? 1 : 0);
        assign sel_dir[i] = swap_seg[SEG];
    end

    assign ang_dir1_o = (dir1_i & ~sel_dir) | (dir0_i & sel_dir);
    assign ang_val1_o = (val1_i & ~swap_seg) | (val0_i & take_seg);

endmodule

`default_nettype wire

//--- source/cordic_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_consts.svh"

module cordic_unit
    import pe_pkg::*;
(
    input  wire               clk,
    input  wire               rst_n,
    input  wire               start_i,
    input  wire cordic_mode_e mode_i,
    input  wire coord_pair_t  pair_i,
    input  wire dir_t         dir_i,
    output coord_pair_t       pair_o,
    output dir_t              dir_o,
    output seg_val_t          seg_val_o
);

    localparam int SEG0_N = `PE_SEG1_FIRST;
    localparam int SEG1_N = `PE_SEG2_FIRST - `PE_SEG1_FIRST;
    localparam int SEG2_N = `PE_ITER_NUM - `PE_SEG2_FIRST;
    localparam int FRAC   = `PE_GAIN_WIDTH - 1;                   // gain is Q14
    localparam int PROD_W = $bits(ext_coord_t) + `PE_GAIN_WIDTH;

    cordic_mode_e mode_q [0:1];    // modes of segments 1 and 2
    ext_coord_t   x_in;
    ext_coord_t   y_in;
    ext_coord_t   x_s [0:2];
    ext_coord_t   y_s [0:2];
    ext_coord_t   x_q [0:2];
    ext_coord_t   y_q [0:2];
    logic signed [PROD_W-1:0] prod_x;
    logic signed [PROD_W-1:0] prod_y;
    coord_pair_t  pair_q;
    logic [SEG0_N-1:0] dir_s0;
    logic [SEG1_N-1:0] dir_s1;
    logic [SEG2_N-1:0] dir_s2;

    // sign, bits 30..14, round on bit 13, wraps to the coordinate width
    function automatic coord_t gain_round(input logic signed [PROD_W-1:0] prod);
        return {prod[PROD_W-1], prod[FRAC+`PE_WIDTH-2:FRAC]}
            + {{(`PE_WIDTH-1){1'b0}}, prod[FRAC-1]};
    endfunction

    assign x_in = ext_coord_t'(pair_i.x);
    assign y_in = ext_coord_t'(pair_i.y);

    cordic_segment #(.FIRST(0), .COUNT(SEG0_N)) u_seg0 (
        .mode_i (mode_i),
        .x_i    (x_in),
        .y_i    (y_in),
        .dir_i  (dir_i[`PE_SEG1_FIRST-1:0]),
        .x_o    (x_s[0]),
        .y_o    (y_s[0]),
        .dir_o  (dir_s0)
    );

    cordic_segment #(.FIRST(`PE_SEG1_FIRST), .COUNT(SEG1_N)) u_seg1 (
        .mode_i (mode_q[0]),
        .x_i    (x_q[0]),
        .y_i    (y_q[0]),
        .dir_i  (dir_i[`PE_SEG2_FIRST-1:`PE_SEG1_FIRST]),
        .x_o    (x_s[1]),
        .y_o    (y_s[1]),
        .dir_o  (dir_s1)
    );

    cordic_segment #(.FIRST(`PE_SEG2_FIRST), .COUNT(SEG2_N)) u_seg2 (
        .mode_i (mode_q[1]),
        .x_i    (x_q[1]),
        .y_i    (y_q[1]),
        .dir_i  (dir_i[`PE_ITER_NUM-1:`PE_SEG2_FIRST]),
        .x_o    (x_s[2]),
        .y_o    (y_s[2]),
        .dir_o  (dir_s2)
    );

    assign prod_x = PROD_W'(x_q[2]) * $signed(PROD_W'(`PE_GAIN));
    assign prod_y = PROD_W'(y_q[2]) * $signed(PROD_W'(`PE_GAIN));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_q[0] <= ROTATE;
            mode_q[1] <= ROTATE;
            for (int s = 0; s < 3; s++) begin
                x_q[s] <= '0;
                y_q[s] <= '0;
            end
            pair_q <= '0;
        end else begin
            mode_q[0] <= start_i ? mode_i : ROTATE;    // idle slot reports no angle
            mode_q[1] <= mode_q[0];
            for (int s = 0; s < 3; s++) begin
                x_q[s] <= x_s[s];
                y_q[s] <= y_s[s];
            end
            pair_q.x <= gain_round(prod_x);
            pair_q.y <= gain_round(prod_y);
        end
    end

    assign pair_o    = pair_q;
    assign dir_o     = {dir_s2, dir_s1, dir_s0};
    assign seg_val_o = {mode_q[1] == VECTOR, mode_q[0] == VECTOR, start_i && mode_i == VECTOR};

endmodule

`default_nettype wire

//--- source/cordic_segment.sv
`timescale 1ns/1ps
`default_nettype none

module cordic_segment
    import pe_pkg::*;
#(
    parameter int FIRST = 0,
    parameter int COUNT = 4
) (
    input  wire cordic_mode_e     mode_i,
    input  wire ext_coord_t       x_i,
    input  wire ext_coord_t       y_i,
    input  wire logic [COUNT-1:0] dir_i,
    output ext_coord_t            x_o,
    output ext_coord_t            y_o,
    output logic [COUNT-1:0]      dir_o
);

    localparam int MSB = $bits(ext_coord_t) - 1;

    logic [COUNT-1:0] dir_used;

    always_comb begin
        ext_coord_t x;
        ext_coord_t y;
        ext_coord_t x_sh;
        ext_coord_t y_sh;

        x = x_i;
        y = y_i;
        for (int k = 0; k < COUNT; k++) begin
            // vectoring turns against the sign of y relative to x
            dir_used[k] = (mode_i == VECTOR) ? (x[MSB] ^ y[MSB]) : dir_i[k];
            x_sh = x >>> (FIRST + k);
            y_sh = y >>> (FIRST + k);
            if (dir_used[k]) begin
                x = x - y_sh;
                y = y + x_sh;
            end else begin
                x = x + y_sh;
                y = y - x_sh;
            end
        end
        x_o = x;
        y_o = y;
    end

    assign dir_o = (mode_i == VECTOR) ? dir_used : '0;    // rotation reports nothing

endmodule

`default_nettype wire

//--- source/pe_pkg.sv
`default_nettype none

`include "pe_consts.svh"

package pe_pkg;

    typedef logic signed [`PE_WIDTH-1:0] coord_t;
    typedef logic signed [`PE_WIDTH:0]   ext_coord_t;    // one guard bit for CORDIC growth
    typedef logic [`PE_ITER_NUM-1:0]     dir_t;          // 1 = subtract y, add x
    typedef logic [`PE_SEG_NUM-1:0]      seg_val_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } coord_pair_t;

    typedef enum logic [0:0] {
        VECTOR = 1'b0,
        ROTATE = 1'b1
    } cordic_mode_e;

    typedef enum logic [1:0] {
        SCHEME_VV      = 2'd0,    // both lanes vector
        SCHEME_RR      = 2'd1,    // both lanes rotate
        SCHEME_SWAP_VR = 2'd2,    // unit 1 follows unit 0's fresh angle
        SCHEME_SWAP_RR = 2'd3
    } pe_scheme_e;

endpackage

`default_nettype wire

//--- source/pe_consts.svh
`ifndef PE_CONSTS_SVH
`define PE_CONSTS_SVH

// coordinate width and number of micro-rotations
`define PE_WIDTH        18
`define PE_ITER_NUM     14
`define PE_SEG_NUM      3

// issue to output, in cycles
`define PE_PIPE_NUM     4

// first iteration of the registered segments
// segment 0 runs iterations 0..3, segment 1 runs 4..8, segment 2 runs 9..13
`define PE_SEG1_FIRST   4
`define PE_SEG2_FIRST   9

// inverse CORDIC gain, about 0.6073 in Q14
`define PE_GAIN_WIDTH   15
`define PE_GAIN         15'b010011011011101

`endif
